/* tb.f */
+incdir+include
+incdir+verif
src/axiLitePkg.sv
src/fetchPkg.sv
src/imemPortIf.sv
src/pcGen.sv
src/instrMem.sv
src/axiLiteLoader.sv
src/fetchTop.sv
verif/fetchTb.sv

/* Bender.yml */
package:
  name: fetch_front_end

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/axiLitePkg.sv
      - src/fetchPkg.sv
      - src/imemPortIf.sv
      - src/pcGen.sv
      - src/instrMem.sv
      - src/axiLiteLoader.sv
      - src/fetchTop.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fetchTb.sv

/* verif/fetchTbUtil.svh */
`ifndef FETCH_TB_UTIL_SVH
`define FETCH_TB_UTIL_SVH

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic lfsrBit();
	logic fb;
	fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
	lfsrState = {lfsrState[14:0], fb};
	return fb;
endfunction

// one lfsr step per bit
function automatic logic [xlen-1:0] randWord();
	logic [xlen-1:0] w;
	w = '0;
	for (int i = 0; i < xlen; i++)
		w = {w[xlen-2:0], lfsrBit()};
	return w;
endfunction

task automatic checkWord(input string what, input logic [xlen-1:0] got,
	input logic [xlen-1:0] exp);
	if (got !== exp)
	begin
		$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		$display("Simulation failed");
		$fatal(1, "word mismatch");
	end
endtask

task automatic checkBit(input string what, input logic got, input logic exp);
	if (got !== exp)
	begin
		$display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		$display("Simulation failed");
		$fatal(1, "flag mismatch");
	end
endtask

task automatic checkResp(input string what, input axiResp_t got, input axiResp_t exp);
	if (got !== exp)
	begin
		$display("** Error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		$display("Simulation failed");
		$fatal(1, "response mismatch");
	end
endtask

task automatic timedOut(input string what);
	$display("Timeout at %0t: %s never came", $time, what);
	$display("Simulation failed");
	$fatal(1, "handshake timeout");
endtask

`endif

/* verif/fetchTb.sv */
`timescale 1ns/10ps

module fetchTb;
	import fetchPkg::*;
	import axiLitePkg::*;

	localparam int maxWait = 50; // cycles per handshake wait

	typedef struct {
		logic stall;
		pcSel_t sel;
		logic [xlen-1:0] tgt;
		logic exc;
		logic [xlen-1:0] epcVal;
		int reps; // cycles this row is held
	} stimRow_t;

	logic clk, nrst, stall, exceptionPending;
	pcSel_t pcSel;
	logic [xlen-1:0] target, epc, pc2, instr2;
	logic misaligned2, fetchValid;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [axiAddrBits-1:0] awaddr, araddr;
	logic [axiDataBits-1:0] wdata, rdata;
	logic [axiStrbBits-1:0] wstrb;
	axiResp_t bresp, rresp;

	logic [15:0] lfsrState = 16'd61;
	logic [xlen-1:0] memModel [imemWords]; // words the tb loaded
	logic [xlen-1:0] pc1M, pc2M, instrM; // reference pipe
	logic misM;
	stimRow_t curRow; // inputs the dut sees at the next edge
	stimRow_t rows [13];

	`include "fetchTbUtil.svh"

	fetchTop dut_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// AW and W together, bready left alone
	task automatic sendWrite(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
		int n;
		logic awHs, wHs;
		n = 0;
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr <= a;
		wvalid <= 1'b1;
		wdata <= d;
		wstrb <= s;
		do
		begin
			@(negedge clk);
			awHs = awvalid && awready;
			wHs = wvalid && wready;
			@(posedge clk);
			if (awHs)
				awvalid <= 1'b0;
			if (wHs)
				wvalid <= 1'b0;
			if (++n > maxWait)
				timedOut("AW/W handshake");
		end
		while (awvalid || wvalid);
	endtask

	task automatic takeWriteResp(output axiResp_t resp);
		int n;
		n = 0;
		bready <= 1'b1;
		do
		begin
			@(negedge clk);
			if (++n > maxWait)
				timedOut("write response bvalid");
		end
		while (!bvalid);
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0; // handshake on this edge
	endtask

	task automatic axiWrite(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s,
		output axiResp_t resp);
		sendWrite(a, d, s);
		takeWriteResp(resp);
	endtask

	task automatic axiRead(input logic [31:0] a, output logic [31:0] d, output axiResp_t resp);
		int n;
		logic arHs;
		n = 0;
		@(posedge clk);
		arvalid <= 1'b1;
		araddr <= a;
		rready <= 1'b1;
		do
		begin
			@(negedge clk);
			arHs = arvalid && arready;
			@(posedge clk);
			if (arHs)
				arvalid <= 1'b0;
			if (++n > maxWait)
				timedOut("AR handshake");
		end
		while (!arHs);
		n = 0;
		while (!rvalid)
		begin
			@(negedge clk);
			if (++n > maxWait)
				timedOut("read data rvalid");
		end
		d = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	function automatic logic [xlen-1:0] nextPc(input stimRow_t r, input logic [xlen-1:0] pc);
		if (r.exc)
			return r.epcVal; // exception beats pcSel
		case (r.sel)
			pcSelReset: return 32'h0;
			pcSelTarget: return r.tgt;
			pcSelHold: return pc;
			default: return pc + 32'd4;
		endcase
	endfunction

	// one clock edge of the reference pipe
	task automatic stepModel();
		if (!curRow.stall)
		begin
			instrM = memModel[pc1M[imemAddrBits+1:2]];
			misM = |pc1M[1:0];
			pc2M = pc1M;
			pc1M = nextPc(curRow, pc1M);
		end
	endtask

	task automatic applyRow(input stimRow_t r);
		stall <= r.stall;
		pcSel <= r.sel;
		target <= r.tgt;
		exceptionPending <= r.exc;
		epc <= r.epcVal;
		curRow = r;
	endtask

	initial
	begin
		axiResp_t resp;
		logic [xlen-1:0] word;
		int n;
		// pc stays below 0x40, inside the loaded words
		rows[0] = '{1'b0, pcSelSeq, 32'h0, 1'b0, 32'h0, 4};
		rows[1] = '{1'b0, pcSelTarget, 32'h08, 1'b0, 32'h0, 1};
		rows[2] = '{1'b0, pcSelSeq, 32'h0, 1'b0, 32'h0, 2};
		rows[3] = '{1'b0, pcSelReset, 32'h0, 1'b0, 32'h0, 1};
		rows[4] = '{1'b0, pcSelSeq, 32'h0, 1'b0, 32'h0, 2};
		rows[5] = '{1'b0, pcSelHold, 32'h0, 1'b0, 32'h0, 2};
		rows[6] = '{1'b0, pcSelTarget, 32'h22, 1'b0, 32'h0, 1}; // misaligned
		rows[7] = '{1'b0, pcSelSeq, 32'h0, 1'b0, 32'h0, 1};
		rows[8] = '{1'b0, pcSelTarget, 32'h30, 1'b1, 32'h10, 1}; // epc wins
		rows[9] = '{1'b1, pcSelSeq, 32'h0, 1'b0, 32'h0, 3}; // frozen
		rows[10] = '{1'b0, pcSelSeq, 32'h0, 1'b0, 32'h0, 3};
		rows[11] = '{1'b0, pcSelTarget, 32'h3C, 1'b0, 32'h0, 1};
		rows[12] = '{1'b0, pcSelHold, 32'h0, 1'b0, 32'h0, 3};

		nrst = 1'b0;
		stall = 1'b1; // front end frozen during load
		pcSel = pcSelHold;
		target = '0;
		exceptionPending = 1'b0;
		epc = '0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (3) @(posedge clk);
		nrst <= 1'b1;
		@(negedge clk);
		checkBit("bvalid after reset", bvalid, 1'b0);
		checkBit("rvalid after reset", rvalid, 1'b0);
		checkBit("fetchValid after reset", fetchValid, 1'b0);
		// readies stay low for the first cycle out of reset
		checkBit("awready after reset", awready, 1'b0);
		checkBit("wready after reset", wready, 1'b0);
		checkBit("arready after reset", arready, 1'b0);

		// program load
		for (int i = 0; i < 16; i++)
		begin
			memModel[i] = randWord();
			axiWrite(i * 4, memModel[i], 4'hF, resp);
			checkResp("load bresp", resp, respOkay);
		end
		axiWrite(32'h0C, 32'hA5A5_A5A5, 4'b0101, resp); // bytes 0 and 2 only
		checkResp("strobe bresp", resp, respOkay);
		memModel[3][7:0] = 8'hA5;
		memModel[3][23:16] = 8'hA5;
		for (int i = 0; i < 16; i++)
		begin
			axiRead(i * 4, word, resp);
			checkResp("readback rresp", resp, respOkay);
			checkWord("readback rdata", word, memModel[i]);
		end

		// release, pc1 held at the reset vector
		@(posedge clk);
		stall <= 1'b0;
		n = 0;
		do
		begin
			@(negedge clk);
			if (++n > maxWait)
				timedOut("fetchValid");
		end
		while (!fetchValid);
		checkWord("first pc2", pc2, 32'h0);
		checkWord("first instr2", instr2, memModel[0]);
		pc1M = 32'h0;
		pc2M = 32'h0;
		curRow = '{1'b0, pcSelHold, 32'h0, 1'b0, 32'h0, 1};

		// table driven fetch sequence
		foreach (rows[r])
		begin
			for (int k = 0; k < rows[r].reps; k++)
			begin
				@(posedge clk);
				stepModel();
				applyRow(rows[r]);
				@(negedge clk);
				checkWord("pc2", pc2, pc2M);
				checkWord("instr2", instr2, instrM);
				checkBit("misaligned2", misaligned2, misM);
			end
		end

		// out of range access, the index would alias word 0
		axiWrite(32'h400, 32'hDEAD_BEEF, 4'hF, resp);
		checkResp("range bresp", resp, respSlvErr);
		axiRead(32'h400, word, resp);
		checkResp("range rresp", resp, respSlvErr);
		checkWord("range rdata", word, 32'h0);
		axiRead(32'h0, word, resp);
		checkWord("word 0 after bad write", word, memModel[0]);

		// bready low holds the response and blocks new writes
		sendWrite(32'h3C, 32'h1234_5678, 4'hF);
		memModel[15] = 32'h1234_5678;
		n = 0;
		do
		begin
			@(negedge clk);
			if (++n > maxWait)
				timedOut("bvalid under back-pressure");
		end
		while (!bvalid);
		repeat (4)
		begin
			@(negedge clk);
			checkBit("held bvalid", bvalid, 1'b1);
			checkBit("awready while blocked", awready, 1'b0);
			checkBit("wready while blocked", wready, 1'b0);
		end
		@(posedge clk);
		takeWriteResp(resp);
		checkResp("held bresp", resp, respOkay);
		axiRead(32'h3C, word, resp);
		checkWord("word 15 readback", word, memModel[15]);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* src/fetchTop.sv */
`timescale 1ns/10ps

module fetchTop (
	input logic clk,
	input logic nrst,
	input logic stall,
	input fetchPkg::pcSel_t pcSel,
	input logic [fetchPkg::xlen-1:0] target,
	input logic exceptionPending,
	input logic [fetchPkg::xlen-1:0] epc,
	output logic [fetchPkg::xlen-1:0] pc2,
	output logic [fetchPkg::xlen-1:0] instr2, // word at pc2, to decode
	output logic misaligned2,
	output logic fetchValid,
	// debug host, AXI4-Lite
	input logic awvalid,
	output logic awready,
	input logic [axiLitePkg::axiAddrBits-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [axiLitePkg::axiDataBits-1:0] wdata,
	input logic [axiLitePkg::axiStrbBits-1:0] wstrb,
	output logic bvalid,
	input logic bready,
	output axiLitePkg::axiResp_t bresp,
	input logic arvalid,
	output logic arready,
	input logic [axiLitePkg::axiAddrBits-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [axiLitePkg::axiDataBits-1:0] rdata,
	output axiLitePkg::axiResp_t rresp
);
	import fetchPkg::*;

	logic rdEn;
	logic [imemAddrBits-1:0] fetchAddr; // pc1 word index

	imemPortIf dbgIf (); // loader to memory debug port

	pcGen pcGen_i (
		.clk, .nrst, .stall, .pcSel, .target,
		.exceptionPending, .epc,
		.pc2, .misaligned2, .fetchValid,
		.rdEn, .fetchAddr
	);

	instrMem instrMem_i (
		.clk, .nrst, .rdEn, .fetchAddr,
		.instr(instr2),
		.dbg(dbgIf.mem)
	);

	axiLiteLoader axiLiteLoader_i (
		.clk, .nrst,
		.awvalid, .awready, .awaddr,
		.wvalid, .wready, .wdata, .wstrb,
		.bvalid, .bready, .bresp,
		.arvalid, .arready, .araddr,
		.rvalid, .rready, .rdata, .rresp,
		.mem(dbgIf.loader)
	);

endmodule

/* src/axiLiteLoader.sv */
`timescale 1ns/10ps

module axiLiteLoader (
	input logic clk,
	input logic nrst,
	input logic awvalid,
	output logic awready,
	input logic [axiLitePkg::axiAddrBits-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [axiLitePkg::axiDataBits-1:0] wdata,
	input logic [axiLitePkg::axiStrbBits-1:0] wstrb,
	output logic bvalid,
	input logic bready,
	output axiLitePkg::axiResp_t bresp,
	input logic arvalid,
	output logic arready,
	input logic [axiLitePkg::axiAddrBits-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [axiLitePkg::axiDataBits-1:0] rdata,
	output axiLitePkg::axiResp_t rresp,
	imemPortIf.loader mem
);
	import axiLitePkg::*;
	import fetchPkg::*;

	logic readyEn; // keeps readies low the first cycle out of reset
	logic awFull, wFull; // capture slots
	logic [axiAddrBits-1:0] awAddrQ;
	logic [axiDataBits-1:0] wDataQ;
	logic [axiStrbBits-1:0] wStrbQ;
	logic arPend; // read address held, not yet on the port
	logic rdWait; // port read issued, data next edge
	logic [axiAddrBits-1:0] arAddrQ;
	logic wrGo, rdGo; // port use this cycle
	logic awInRange, arInRange;

	// in range when below 4 * imemWords bytes
	assign awInRange = ~|awAddrQ[axiAddrBits-1:imemAddrBits+2];
	assign arInRange = ~|arAddrQ[axiAddrBits-1:imemAddrBits+2];

	assign wrGo = awFull & wFull; // write wins the port
	assign rdGo = arPend & ~wrGo;

	assign awready = readyEn & ~awFull & ~bvalid;
	assign wready = readyEn & ~wFull & ~bvalid;
	assign arready = readyEn & ~arPend & ~rdWait & ~rvalid; // one read in flight

	// memory port, byte address to word index
	assign mem.we = wrGo & awInRange; // out of range write is dropped
	assign mem.addr = wrGo ? awAddrQ[imemAddrBits+1:2] : arAddrQ[imemAddrBits+1:2];
	assign mem.wdata = wDataQ;
	assign mem.strb = wStrbQ;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			readyEn <= 1'b0;
			awFull <= 1'b0;
			wFull <= 1'b0;
			bvalid <= 1'b0;
			arPend <= 1'b0;
			rdWait <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			readyEn <= 1'b1;
			// write side
			if (awvalid && awready)
				awFull <= 1'b1;
			else if (wrGo)
				awFull <= 1'b0;
			if (wvalid && wready)
				wFull <= 1'b1;
			else if (wrGo)
				wFull <= 1'b0;
			if (wrGo)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0; // held until accepted
			// read side, two edges from AR to R
			if (arvalid && arready)
				arPend <= 1'b1;
			else if (rdGo)
				arPend <= 1'b0;
			rdWait <= rdGo;
			if (rdWait)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// capture and response payload
	always_ff @(posedge clk)
	begin
		if (awvalid && awready)
			awAddrQ <= awaddr;
		if (wvalid && wready)
		begin
			wDataQ <= wdata;
			wStrbQ <= wstrb;
		end
		if (arvalid && arready)
			arAddrQ <= araddr;
		if (wrGo)
			bresp <= awInRange ? respOkay : respSlvErr;
		if (rdWait)
		begin
			rdata <= arInRange ? mem.rdata : '0; // zero on error
			rresp <= arInRange ? respOkay : respSlvErr;
		end
	end

endmodule

/* src/instrMem.sv */
`timescale 1ns/10ps

module instrMem (
	input logic clk,
	input logic nrst,
	input logic rdEn, // low while stalled
	input logic [fetchPkg::imemAddrBits-1:0] fetchAddr,
	output logic [fetchPkg::xlen-1:0] instr,
	imemPortIf.mem dbg
);
	import fetchPkg::*;

	logic [xlen-1:0] mem [imemWords]; // program storage

	// fetch port, output register holds when rdEn low
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			instr <= '0;
		end
		else if (rdEn)
		begin
			instr <= mem[fetchAddr];
		end
	end

	// debug write, per byte lane
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < xlen/8; i++)
		begin
			if (dbg.we && dbg.strb[i])
			begin
				mem[dbg.addr][8*i +: 8] <= dbg.wdata[8*i +: 8];
			end
		end
	end

	// debug read, old data on same address write
	always_ff @(posedge clk)
	begin
		dbg.rdata <= mem[dbg.addr];
	end

endmodule

/* src/pcGen.sv */
`timescale 1ns/10ps

module pcGen (
	input logic clk,
	input logic nrst,
	input logic stall, // freezes the whole front end
	input fetchPkg::pcSel_t pcSel,
	input logic [fetchPkg::xlen-1:0] target,
	input logic exceptionPending, // overrides pcSel
	input logic [fetchPkg::xlen-1:0] epc,
	output logic [fetchPkg::xlen-1:0] pc2,
	output logic misaligned2,
	output logic fetchValid,
	output logic rdEn,
	output logic [fetchPkg::imemAddrBits-1:0] fetchAddr
);
	import fetchPkg::*;

	logic [xlen-1:0] pc1; // pipe stage 1, address sent to memory
	logic [xlen-1:0] npc; // next pc1

	// next address, exception first
	always_comb
	begin
		if (exceptionPending)
		begin
			npc = epc;
		end
		else
		begin
			case (pcSel)
				pcSelSeq: npc = pc1 + xlen'(4);
				pcSelReset: npc = resetVector;
				pcSelTarget: npc = target;
				pcSelHold: npc = pc1; // refetch
				default: npc = pc1 + xlen'(4);
			endcase
		end
	end

	// two stage address pipe, everything holds on stall
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc1 <= resetVector;
			pc2 <= resetVector;
			misaligned2 <= 1'b0;
			fetchValid <= 1'b0;
		end
		else if (!stall)
		begin
			pc1 <= npc;
			pc2 <= pc1; // lines up with instr from memory
			misaligned2 <= |pc1[1:0]; // not word aligned
			fetchValid <= 1'b1; // first unstalled edge after reset
		end
	end

	// memory read follows pc1, same edge as pc2 update
	assign rdEn = ~stall;
	assign fetchAddr = pc1[imemAddrBits+1:2]; // upper bits dropped, wraps

endmodule

/* src/imemPortIf.sv */
`timescale 1ns/10ps

// debug side port of the instruction memory
interface imemPortIf;
	import fetchPkg::*;

	logic we; // one cycle write pulse
	logic [imemAddrBits-1:0] addr; // word index, not byte address
	logic [xlen-1:0] wdata;
	logic [xlen/8-1:0] strb; // byte lanes to update
	logic [xlen-1:0] rdata; // word at addr, one cycle later

	modport loader (
		output we, addr, wdata, strb,
		input rdata
	);

	modport mem (
		input we, addr, wdata, strb,
		output rdata
	);

endinterface

/* src/fetchPkg.sv */
`include "fetchDefs.svh"

package fetchPkg;

	localparam int xlen = 32; // data and address width
	localparam int imemWords = `IMEM_WORDS;
	localparam int imemAddrBits = $clog2(imemWords); // word index width

	localparam logic [xlen-1:0] resetVector = `RESET_VECTOR;

	// next fetch address source
	typedef enum logic [1:0] {
		pcSelSeq = 2'b00, // pc1 + 4
		pcSelReset = 2'b01, // back to resetVector
		pcSelTarget = 2'b10, // branch / jump target
		pcSelHold = 2'b11 // refetch same address
	} pcSel_t;

endpackage

/* src/axiLitePkg.sv */
package axiLitePkg;

	localparam int axiAddrBits = 32;
	localparam int axiDataBits = 32;
	localparam int axiStrbBits = axiDataBits / 8; // one strobe per byte

	// only the two codes the loader ever returns
	typedef enum logic [1:0] {
		respOkay = 2'b00,
		respSlvErr = 2'b10
	} axiResp_t;

endpackage

/* include/fetchDefs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// first fetch address after reset
`define RESET_VECTOR 32'h0000_0000

`endif
